/* logic/gemm_defs.svh */
//##################################################
// gemm accelerator constants
// tile geometry, element width, burst shape, read IDs
//##################################################

`ifndef GEMM_DEFS_SVH
`define GEMM_DEFS_SVH

// array is square, one PE per output element
`define GEMM_SA_WIDTH 4

// signed element width in bits
`define GEMM_DW 32

// one tile per burst, one element per beat
`define GEMM_BURST_LEN 16
`define GEMM_TILE_BYTES 64

// read IDs, A always requested first
`define GEMM_ID_A 0
`define GEMM_ID_B 1

`endif

/* logic/axi_pkg.sv */
//##################################################
// axi field types
// widths of the AXI channel fields used by the DMA
//##################################################

package axi_pkg;

    // byte address and one 32-bit beat
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;

    typedef logic [3:0] axi_id_t;

    // beats minus one
    typedef logic [7:0] axi_len_t;

    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;

endpackage

/* logic/gemm_pkg.sv */
//##################################################
// gemm accelerator types
// elements, buffer rows, result tile, DMA FSM states
//##################################################

`include "gemm_defs.svh"

package gemm_pkg;

    typedef logic signed [`GEMM_DW-1:0] elem_t;

    // word n at bit offset 32*n
    typedef logic [`GEMM_SA_WIDTH*`GEMM_DW-1:0] buf_row_t;
    typedef logic [$clog2(`GEMM_SA_WIDTH)-1:0] buf_addr_t;

    // element i*4+j at bit offset 32*(i*4+j)
    typedef logic [`GEMM_SA_WIDTH*`GEMM_SA_WIDTH*`GEMM_DW-1:0] c_tile_t;

    typedef enum logic [2:0] {
        IDLE,
        ADDR_A,
        ADDR_B,
        LOAD,
        WAIT_MM,
        ADDR_C,
        WRITE_C,
        WAIT_B
    } dma_state_t;

endpackage

/* logic/tile_buffer.sv */
//##################################################
// tile buffer
// four 128-bit rows, one write port, registered read
//##################################################

module tile_buffer
    import gemm_pkg::*;
(
    input  logic      clk,

    input  logic      wren_i,
    input  buf_addr_t waddr_i,
    input  buf_row_t  wdata_i,

    input  buf_addr_t raddr_i,
    output buf_row_t  rdata_o
);

    buf_row_t mem [4];

    always_ff @(posedge clk) begin
        if (wren_i) begin
            mem[waddr_i] <= wdata_i;
        end
        // one cycle read latency
        rdata_o <= mem[raddr_i];
    end

endmodule

/* logic/systolic_mm.sv */
//##################################################
// 4x4 output-stationary systolic multiplier
// A streams right, B streams down, each PE accumulates
//##################################################

`include "gemm_defs.svh"

module systolic_mm
    import gemm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      start_i,
    output logic      done_o,

    output buf_addr_t buf_a_raddr_o,
    output buf_addr_t buf_b_raddr_o,
    input  buf_row_t  buf_a_rdata_i,
    input  buf_row_t  buf_b_rdata_i,

    output c_tile_t   c_tile_o
);

    localparam int N  = `GEMM_SA_WIDTH;
    localparam int DW = `GEMM_DW;
    // last product reaches PE(N-1,N-1) at this count
    localparam logic [3:0] LAST_CNT = 4'(3*N - 2);

    logic       busy_q;
    logic [3:0] cnt_q;
    // buffer rows on the read port are live
    logic       rd_vld_q;

    buf_row_t a_row;
    buf_row_t b_row;
    // past rows, index d is d+1 cycles old
    buf_row_t a_hist_q [N-1];
    buf_row_t b_hist_q [N-1];
    elem_t    a_feed   [N];
    elem_t    b_feed   [N];

    // operand registers between neighbouring PEs
    elem_t a_pe_q [N][N-1];
    elem_t b_pe_q [N-1][N];
    elem_t a_in   [N][N];
    elem_t b_in   [N][N];
    elem_t acc_q  [N][N];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            cnt_q    <= '0;
            rd_vld_q <= 1'b0;
            done_o   <= 1'b0;
        end else if (start_i) begin
            busy_q   <= 1'b1;
            cnt_q    <= '0;
            rd_vld_q <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            rd_vld_q <= busy_q && (cnt_q < 4'(N));
            if (busy_q) begin
                cnt_q <= cnt_q + 4'd1;
                if (cnt_q == LAST_CNT) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // row k of both buffers on counts 0..3
    assign buf_a_raddr_o = cnt_q[1:0];
    assign buf_b_raddr_o = cnt_q[1:0];

    // zeros outside the window keep stray products out of the sums
    assign a_row = rd_vld_q ? buf_a_rdata_i : '0;
    assign b_row = rd_vld_q ? buf_b_rdata_i : '0;

    always_ff @(posedge clk) begin
        a_hist_q[0] <= a_row;
        b_hist_q[0] <= b_row;
        for (int d = 1; d < N-1; d++) begin
            a_hist_q[d] <= a_hist_q[d-1];
            b_hist_q[d] <= b_hist_q[d-1];
        end
    end

    // skew: lane i takes its word from the row i cycles back
    always_comb begin
        a_feed[0] = a_row[DW-1:0];
        b_feed[0] = b_row[DW-1:0];
        for (int i = 1; i < N; i++) begin
            a_feed[i] = a_hist_q[i-1][DW*i +: DW];
            b_feed[i] = b_hist_q[i-1][DW*i +: DW];
        end
    end

    // array edge gets the feed, inner PEs the neighbour register
    always_comb begin
        for (int i = 0; i < N; i++) begin
            a_in[i][0] = a_feed[i];
            b_in[0][i] = b_feed[i];
            for (int j = 1; j < N; j++) begin
                a_in[i][j] = a_pe_q[i][j-1];
                b_in[j][i] = b_pe_q[j-1][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                // low 32 bits only, wraps on overflow
                if (start_i) begin
                    acc_q[i][j] <= '0;
                end else begin
                    acc_q[i][j] <= acc_q[i][j] + a_in[i][j] * b_in[i][j];
                end
            end
            for (int j = 0; j < N-1; j++) begin
                a_pe_q[i][j] <= a_in[i][j];
                b_pe_q[j][i] <= b_in[j][i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                c_tile_o[DW*(i*N+j) +: DW] = acc_q[i][j];
            end
        end
    end

endmodule

/* logic/dma_engine.sv */
//##################################################
// gemm DMA engine
// fetches tiles A and B over AXI, starts the array,
// then writes tile C back in one burst
//##################################################

`include "gemm_defs.svh"

module dma_engine
    import axi_pkg::*;
    import gemm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // job configuration
    input  axi_addr_t  mat_a_addr_i,
    input  axi_addr_t  mat_b_addr_i,
    input  axi_addr_t  mat_c_addr_i,
    input  logic       start_i,
    output logic       done_o,

    // AR channel
    output logic       arvalid_o,
    input  logic       arready_i,
    output axi_addr_t  araddr_o,
    output axi_id_t    arid_o,
    output axi_len_t   arlen_o,
    output axi_size_t  arsize_o,
    output axi_burst_t arburst_o,

    // R channel
    input  logic       rvalid_i,
    output logic       rready_o,
    input  axi_id_t    rid_i,
    input  axi_data_t  rdata_i,
    input  logic       rlast_i,
    input  axi_resp_t  rresp_i,

    // AW channel
    output logic       awvalid_o,
    input  logic       awready_i,
    output axi_addr_t  awaddr_o,
    output axi_id_t    awid_o,
    output axi_len_t   awlen_o,
    output axi_size_t  awsize_o,
    output axi_burst_t awburst_o,

    // W channel
    output logic       wvalid_o,
    input  logic       wready_i,
    output axi_data_t  wdata_o,
    output logic [3:0] wstrb_o,
    output logic       wlast_o,

    // B channel, response codes not acted on
    input  logic       bvalid_i,
    output logic       bready_o,
    input  axi_id_t    bid_i,
    input  axi_resp_t  bresp_i,

    // tile buffer write ports
    output logic       buf_a_wren_o,
    output buf_addr_t  buf_a_waddr_o,
    output buf_row_t   buf_a_wdata_o,
    output logic       buf_b_wren_o,
    output buf_addr_t  buf_b_waddr_o,
    output buf_row_t   buf_b_wdata_o,

    // multiplier handshake and result
    output logic       mm_start_o,
    input  logic       mm_done_i,
    input  c_tile_t    c_tile_i
);

    localparam axi_len_t   BURST_LEN  = axi_len_t'(`GEMM_BURST_LEN - 1);
    // 4-byte beats, INCR bursts
    localparam axi_size_t  BEAT_SIZE  = 3'd2;
    localparam axi_burst_t BURST_INCR = 2'b01;
    localparam axi_id_t    ID_A       = axi_id_t'(`GEMM_ID_A);
    localparam axi_id_t    ID_B       = axi_id_t'(`GEMM_ID_B);

    dma_state_t state_q;
    dma_state_t state_d;

    logic       beat_a;
    logic       beat_b;
    // beat index within each read burst
    logic [3:0] cnt_a_q;
    logic [3:0] cnt_b_q;
    // last row of each tile handed to its buffer
    logic       fin_a_q;
    logic       fin_b_q;
    // beat index of the C write burst
    logic [3:0] wcnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = ADDR_A;
            ADDR_A:  if (arready_i) state_d = ADDR_B;
            ADDR_B:  if (arready_i) state_d = LOAD;
            LOAD:    if (fin_a_q && fin_b_q) state_d = WAIT_MM;
            // done still high from the last job while start is out
            WAIT_MM: if (mm_done_i && !mm_start_o) state_d = ADDR_C;
            ADDR_C:  if (awready_i) state_d = WRITE_C;
            WRITE_C: if (wready_i && wlast_o) state_d = WAIT_B;
            WAIT_B:  if (bvalid_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // route read beats by ID
    assign beat_a = rvalid_i && rready_o && (rid_i == ID_A);
    assign beat_b = rvalid_i && rready_o && (rid_i == ID_B);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_a_q      <= '0;
            cnt_b_q      <= '0;
            fin_a_q      <= 1'b0;
            fin_b_q      <= 1'b0;
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
            mm_start_o   <= 1'b0;
        end else begin
            // a row is complete on its 4th word
            buf_a_wren_o <= beat_a && (cnt_a_q[1:0] == 2'd3);
            buf_b_wren_o <= beat_b && (cnt_b_q[1:0] == 2'd3);
            // fires while the final row write is on the port
            mm_start_o   <= (state_q == LOAD) && fin_a_q && fin_b_q;
            if (state_q == IDLE) begin
                cnt_a_q <= '0;
                cnt_b_q <= '0;
                fin_a_q <= 1'b0;
                fin_b_q <= 1'b0;
            end
            if (beat_a) begin
                cnt_a_q <= cnt_a_q + 4'd1;
                if (rlast_i) fin_a_q <= 1'b1;
            end
            if (beat_b) begin
                cnt_b_q <= cnt_b_q + 4'd1;
                if (rlast_i) fin_b_q <= 1'b1;
            end
        end
    end

    // word insert, row number taken from the beat count
    always_ff @(posedge clk) begin
        if (beat_a) begin
            buf_a_wdata_o[32*cnt_a_q[1:0] +: 32] <= rdata_i;
            buf_a_waddr_o <= cnt_a_q[3:2];
        end
        if (beat_b) begin
            buf_b_wdata_o[32*cnt_b_q[1:0] +: 32] <= rdata_i;
            buf_b_waddr_o <= cnt_b_q[3:2];
        end
    end

    // C beat counter wraps to 0 after beat 15
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wcnt_q <= '0;
        end else if (wvalid_o && wready_i) begin
            wcnt_q <= wcnt_q + 4'd1;
        end
    end

    assign done_o    = (state_q == IDLE);

    // A request first, then B
    assign arvalid_o = (state_q == ADDR_A) || (state_q == ADDR_B);
    assign araddr_o  = (state_q == ADDR_B) ? mat_b_addr_i : mat_a_addr_i;
    assign arid_o    = (state_q == ADDR_B) ? ID_B : ID_A;
    assign arlen_o   = BURST_LEN;
    assign arsize_o  = BEAT_SIZE;
    assign arburst_o = BURST_INCR;
    assign rready_o  = (state_q == LOAD);

    assign awvalid_o = (state_q == ADDR_C);
    assign awaddr_o  = mat_c_addr_i;
    assign awid_o    = ID_A;
    assign awlen_o   = BURST_LEN;
    assign awsize_o  = BEAT_SIZE;
    assign awburst_o = BURST_INCR;

    // beat i*4+j carries C[i][j], held until wready
    assign wvalid_o  = (state_q == WRITE_C);
    assign wdata_o   = c_tile_i[32*wcnt_q +: 32];
    assign wstrb_o   = '1;
    assign wlast_o   = (state_q == WRITE_C) && (wcnt_q == 4'd15);
    assign bready_o  = (state_q == WAIT_B);

endmodule

/* logic/gemm_accel.sv */
//##################################################
// gemm accelerator top
// DMA engine, two tile buffers and systolic multiplier
//##################################################

module gemm_accel
    import axi_pkg::*;
    import gemm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  axi_addr_t  mat_a_addr_i,
    input  axi_addr_t  mat_b_addr_i,
    input  axi_addr_t  mat_c_addr_i,
    input  logic       start_i,
    output logic       done_o,

    output logic       arvalid_o,
    input  logic       arready_i,
    output axi_addr_t  araddr_o,
    output axi_id_t    arid_o,
    output axi_len_t   arlen_o,
    output axi_size_t  arsize_o,
    output axi_burst_t arburst_o,

    input  logic       rvalid_i,
    output logic       rready_o,
    input  axi_id_t    rid_i,
    input  axi_data_t  rdata_i,
    input  logic       rlast_i,
    input  axi_resp_t  rresp_i,

    output logic       awvalid_o,
    input  logic       awready_i,
    output axi_addr_t  awaddr_o,
    output axi_id_t    awid_o,
    output axi_len_t   awlen_o,
    output axi_size_t  awsize_o,
    output axi_burst_t awburst_o,

    output logic       wvalid_o,
    input  logic       wready_i,
    output axi_data_t  wdata_o,
    output logic [3:0] wstrb_o,
    output logic       wlast_o,

    input  logic       bvalid_i,
    output logic       bready_o,
    input  axi_id_t    bid_i,
    input  axi_resp_t  bresp_i
);

    // buffer write side, from the DMA
    logic      buf_a_wren;
    buf_addr_t buf_a_waddr;
    buf_row_t  buf_a_wdata;
    logic      buf_b_wren;
    buf_addr_t buf_b_waddr;
    buf_row_t  buf_b_wdata;

    // buffer read side, from the multiplier
    buf_addr_t buf_a_raddr;
    buf_row_t  buf_a_rdata;
    buf_addr_t buf_b_raddr;
    buf_row_t  buf_b_rdata;

    logic      mm_start;
    logic      mm_done;
    c_tile_t   c_tile;

    dma_engine u_dma_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .mat_a_addr_i  (mat_a_addr_i),
        .mat_b_addr_i  (mat_b_addr_i),
        .mat_c_addr_i  (mat_c_addr_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .arvalid_o     (arvalid_o),
        .arready_i     (arready_i),
        .araddr_o      (araddr_o),
        .arid_o        (arid_o),
        .arlen_o       (arlen_o),
        .arsize_o      (arsize_o),
        .arburst_o     (arburst_o),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready_o),
        .rid_i         (rid_i),
        .rdata_i       (rdata_i),
        .rlast_i       (rlast_i),
        .rresp_i       (rresp_i),
        .awvalid_o     (awvalid_o),
        .awready_i     (awready_i),
        .awaddr_o      (awaddr_o),
        .awid_o        (awid_o),
        .awlen_o       (awlen_o),
        .awsize_o      (awsize_o),
        .awburst_o     (awburst_o),
        .wvalid_o      (wvalid_o),
        .wready_i      (wready_i),
        .wdata_o       (wdata_o),
        .wstrb_o       (wstrb_o),
        .wlast_o       (wlast_o),
        .bvalid_i      (bvalid_i),
        .bready_o      (bready_o),
        .bid_i         (bid_i),
        .bresp_i       (bresp_i),
        .buf_a_wren_o  (buf_a_wren),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_wren_o  (buf_b_wren),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .c_tile_i      (c_tile)
    );

    // row k of A holds column k of A
    tile_buffer tile_buf_a (
        .clk     (clk),
        .wren_i  (buf_a_wren),
        .waddr_i (buf_a_waddr),
        .wdata_i (buf_a_wdata),
        .raddr_i (buf_a_raddr),
        .rdata_o (buf_a_rdata)
    );

    // row k of B holds row k of B
    tile_buffer tile_buf_b (
        .clk     (clk),
        .wren_i  (buf_b_wren),
        .waddr_i (buf_b_waddr),
        .wdata_i (buf_b_wdata),
        .raddr_i (buf_b_raddr),
        .rdata_o (buf_b_rdata)
    );

    systolic_mm u_systolic_mm (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (mm_start),
        .done_o        (mm_done),
        .buf_a_raddr_o (buf_a_raddr),
        .buf_b_raddr_o (buf_b_raddr),
        .buf_a_rdata_i (buf_a_rdata),
        .buf_b_rdata_i (buf_b_rdata),
        .c_tile_o      (c_tile)
    );

endmodule

/* tests/axi_mem_model.sv */
//##################################################
// AXI slave memory model
// random stalls, interleaved read data, protocol checks
//##################################################

module axi_mem_model
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       arvalid_i,
    output logic       arready_o,
    input  axi_addr_t  araddr_i,
    input  axi_id_t    arid_i,
    input  axi_len_t   arlen_i,
    input  axi_size_t  arsize_i,
    input  axi_burst_t arburst_i,

    output logic       rvalid_o,
    input  logic       rready_i,
    output axi_id_t    rid_o,
    output axi_data_t  rdata_o,
    output logic       rlast_o,
    output axi_resp_t  rresp_o,

    input  logic       awvalid_i,
    output logic       awready_o,
    input  axi_addr_t  awaddr_i,
    input  axi_id_t    awid_i,
    input  axi_len_t   awlen_i,
    input  axi_size_t  awsize_i,
    input  axi_burst_t awburst_i,

    input  logic       wvalid_i,
    output logic       wready_o,
    input  axi_data_t  wdata_i,
    input  logic [3:0] wstrb_i,
    input  logic       wlast_i,

    output logic       bvalid_o,
    input  logic       bready_i,
    output axi_id_t    bid_o,
    output axi_resp_t  bresp_o,

    output logic       err_o
);

    // sparse word store, keyed by byte address
    axi_data_t  mem [axi_addr_t];

    // one read slot per ID
    logic       rd_busy [2];
    axi_addr_t  rd_addr [2];
    logic [4:0] rd_cnt  [2];
    int         cur;

    axi_addr_t  wr_addr;
    logic [4:0] wr_cnt;
    logic       wr_open;
    logic       b_pend;
    axi_id_t    b_id;

    // last W beat seen stalled, for the hold check
    logic       w_stall_q;
    axi_data_t  w_data_q;
    logic       w_last_q;

    // untouched words read back as a pattern of their own address
    function automatic axi_data_t fill_word(input axi_addr_t addr);
        return addr ^ 32'h5a5a_c3c3;
    endfunction

    function automatic axi_data_t read_word(input axi_addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fill_word(addr);
    endfunction

    task automatic write_word(input axi_addr_t addr, input axi_data_t data);
        mem[addr] = data;
    endtask

    task automatic violation(input string what);
        $display("protocol violation at %0t: %s", $time, what);
        err_o <= 1'b1;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            arready_o  <= 1'b0;
            rvalid_o   <= 1'b0;
            rid_o      <= '0;
            rdata_o    <= '0;
            rlast_o    <= 1'b0;
            rresp_o    <= '0;
            awready_o  <= 1'b0;
            wready_o   <= 1'b0;
            bvalid_o   <= 1'b0;
            bid_o      <= '0;
            bresp_o    <= '0;
            err_o      <= 1'b0;
            w_stall_q  <= 1'b0;
            rd_busy[0] = 1'b0;
            rd_busy[1] = 1'b0;
            wr_open    = 1'b0;
            b_pend     = 1'b0;
        end else begin
            // read requests
            if (arvalid_i && arready_o) begin
                if (arlen_i != 8'd15 || arsize_i != 3'd2 || arburst_i != 2'b01) begin
                    violation("read burst is not 16 beats of 4 bytes INCR");
                end
                if (arid_i > 4'd1 || rd_busy[arid_i[0]]) begin
                    violation("read request with an unknown or busy ID");
                end else begin
                    rd_busy[arid_i[0]] = 1'b1;
                    rd_addr[arid_i[0]] = araddr_i;
                    rd_cnt[arid_i[0]]  = '0;
                end
            end
            arready_o <= ($urandom % 3) != 0;

            // read data, beat held until taken
            if (rvalid_o && rready_i) begin
                rd_cnt[cur] = rd_cnt[cur] + 5'd1;
                if (rd_cnt[cur] == 5'd16) begin
                    rd_busy[cur] = 1'b0;
                end
            end
            if (!rvalid_o || rready_i) begin
                rvalid_o <= 1'b0;
                if ((rd_busy[0] || rd_busy[1]) && ($urandom % 4) != 0) begin
                    // random pick when both IDs are open
                    if (rd_busy[0] && rd_busy[1]) begin
                        cur = $urandom % 2;
                    end else begin
                        cur = rd_busy[1] ? 1 : 0;
                    end
                    rvalid_o <= 1'b1;
                    rid_o    <= axi_id_t'(cur);
                    rdata_o  <= read_word(rd_addr[cur] + axi_addr_t'(rd_cnt[cur]) * 4);
                    rlast_o  <= (rd_cnt[cur] == 5'd15);
                end
            end

            // write address
            if (awvalid_i && awready_o) begin
                if (awlen_i != 8'd15 || awsize_i != 3'd2 || awburst_i != 2'b01) begin
                    violation("write burst is not 16 beats of 4 bytes INCR");
                end
                wr_open = 1'b1;
                wr_addr = awaddr_i;
                wr_cnt  = '0;
                b_id    = awid_i;
            end
            awready_o <= !wr_open && !b_pend && ($urandom % 3) != 0;

            // write data must hold while stalled
            if (wvalid_i && w_stall_q && (wdata_i != w_data_q || wlast_i != w_last_q)) begin
                violation("write beat changed while wready was low");
            end
            if (wvalid_i && wready_o) begin
                if (wstrb_i != 4'hf) begin
                    violation("write strobe is not all ones");
                end
                if (wlast_i != (wr_cnt == 5'd15)) begin
                    violation("wlast is not on the 16th beat");
                end
                mem[wr_addr + axi_addr_t'(wr_cnt) * 4] = wdata_i;
                wr_cnt = wr_cnt + 5'd1;
                if (wr_cnt == 5'd16) begin
                    wr_open = 1'b0;
                    b_pend  = 1'b1;
                end
            end
            w_stall_q <= wvalid_i && !wready_o;
            w_data_q  <= wdata_i;
            w_last_q  <= wlast_i;
            wready_o  <= wr_open && ($urandom % 3) != 0;

            // one response per burst
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end else if (b_pend && !bvalid_o && ($urandom % 2) != 0) begin
                bvalid_o <= 1'b1;
                bid_o    <= b_id;
                b_pend   = 1'b0;
            end
        end
    end

endmodule

/* tests/tb_gemm_accel.sv */
//##################################################
// gemm accelerator testbench
// random jobs against a reference multiply
//##################################################

`include "gemm_defs.svh"

module tb_gemm_accel
    import axi_pkg::*;
    import gemm_pkg::*;
();

    // 1 single, 20 back to back, 3 near the signed limits
    localparam int NUM_JOBS = 24;
    localparam int N        = `GEMM_SA_WIDTH;

    logic       clk = 1'b0;
    logic       rst_n;
    axi_addr_t  mat_a_addr;
    axi_addr_t  mat_b_addr;
    axi_addr_t  mat_c_addr;
    logic       start_i;
    logic       done_o;

    logic       arvalid, arready, rvalid, rready, rlast;
    axi_addr_t  araddr, awaddr;
    axi_id_t    arid, rid, awid, bid;
    axi_len_t   arlen, awlen;
    axi_size_t  arsize, awsize;
    axi_burst_t arburst, awburst;
    axi_data_t  rdata, wdata;
    axi_resp_t  rresp, bresp;
    logic       awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [3:0] wstrb;
    logic       mem_err;

    // running handshake counts
    int ar_cnt = 0;
    int aw_cnt = 0;

    always #5 clk = ~clk;

    gemm_accel UUT (
        .clk(clk), .rst_n(rst_n),
        .mat_a_addr_i(mat_a_addr), .mat_b_addr_i(mat_b_addr), .mat_c_addr_i(mat_c_addr),
        .start_i(start_i), .done_o(done_o),
        .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arid_o(arid),
        .arlen_o(arlen), .arsize_o(arsize), .arburst_o(arburst),
        .rvalid_i(rvalid), .rready_o(rready), .rid_i(rid), .rdata_i(rdata),
        .rlast_i(rlast), .rresp_i(rresp),
        .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awid_o(awid),
        .awlen_o(awlen), .awsize_o(awsize), .awburst_o(awburst),
        .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
        .wlast_o(wlast),
        .bvalid_i(bvalid), .bready_o(bready), .bid_i(bid), .bresp_i(bresp)
    );

    axi_mem_model u_mem (
        .clk(clk), .rst_n(rst_n),
        .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arid_i(arid),
        .arlen_i(arlen), .arsize_i(arsize), .arburst_i(arburst),
        .rvalid_o(rvalid), .rready_i(rready), .rid_o(rid), .rdata_o(rdata),
        .rlast_o(rlast), .rresp_o(rresp),
        .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awid_i(awid),
        .awlen_i(awlen), .awsize_i(awsize), .awburst_i(awburst),
        .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
        .wlast_i(wlast),
        .bvalid_o(bvalid), .bready_i(bready), .bid_o(bid), .bresp_o(bresp),
        .err_o(mem_err)
    );

    task automatic check_elem(input string name, input elem_t got, input elem_t exp);
        if (got !== exp) begin
            $display("Test FAILED");
            $fatal(1, "mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) begin
            $display("Test FAILED");
            $fatal(1, "mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input axi_len_t got, input axi_len_t exp);
        if (got !== exp) begin
            $display("Test FAILED");
            $fatal(1, "mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) begin
            $display("Test FAILED");
            $fatal(1, "mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Test FAILED");
            $fatal(1, "mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // values at or next to the signed limits
    function automatic elem_t limit_value();
        case ($urandom % 4)
            0:       return 32'h7fff_ffff;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            default: return 32'h8000_0001;
        endcase
    endfunction

    // request fields, A then B within every job
    always @(posedge clk) begin
        if (rst_n && arvalid && arready) begin
            if (ar_cnt % 2 == 0) begin
                check_addr("araddr of A", araddr, mat_a_addr);
                check_id("arid of A", arid, 4'd0);
            end else begin
                check_addr("araddr of B", araddr, mat_b_addr);
                check_id("arid of B", arid, 4'd1);
            end
            check_len("arlen", arlen, 8'd15);
            ar_cnt <= ar_cnt + 1;
        end
        if (rst_n && awvalid && awready) begin
            check_addr("awaddr", awaddr, mat_c_addr);
            check_id("awid", awid, 4'd0);
            check_len("awlen", awlen, 8'd15);
            aw_cnt <= aw_cnt + 1;
        end
    end

    always @(posedge clk) begin
        if (mem_err) begin
            $display("Test FAILED");
            $fatal(1, "memory model saw an AXI protocol violation");
        end
    end

    initial begin
        repeat (2000 * NUM_JOBS) @(posedge clk);
        $display("Test FAILED");
        $fatal(1, "timeout: jobs did not finish within %0d cycles", 2000 * NUM_JOBS);
    end

    task automatic run_job(input bit near_limit);
        int        slot_a;
        int        slot_b;
        int        slot_c;
        int        ar_start;
        int        aw_start;
        elem_t     a [N][N];
        elem_t     b [N][N];
        elem_t     c_exp;
        axi_addr_t c_base;

        // 128-byte slots leave an unused gap above every tile
        slot_a = 1 + $urandom % 255;
        do slot_b = 1 + $urandom % 255; while (slot_b == slot_a);
        do slot_c = 1 + $urandom % 255; while (slot_c == slot_a || slot_c == slot_b);
        c_base = axi_addr_t'(slot_c * 128);

        // A column-major, B row-major
        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < N; k++) begin
                a[i][k] = near_limit ? limit_value() : elem_t'($urandom);
                b[i][k] = near_limit ? limit_value() : elem_t'($urandom);
                u_mem.write_word(axi_addr_t'(slot_a * 128 + 4 * (k * N + i)), a[i][k]);
                u_mem.write_word(axi_addr_t'(slot_b * 128 + 4 * (i * N + k)), b[i][k]);
            end
        end

        ar_start = ar_cnt;
        aw_start = aw_cnt;
        @(posedge clk);
        mat_a_addr <= axi_addr_t'(slot_a * 128);
        mat_b_addr <= axi_addr_t'(slot_b * 128);
        mat_c_addr <= c_base;
        start_i    <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        check_flag("done_o after start", done_o, 1'b0);
        // stray start while busy must be ignored
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        while (!done_o) @(negedge clk);

        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                c_exp = '0;
                for (int k = 0; k < N; k++) begin
                    // 32-bit product and sum, wraps like the array
                    c_exp = c_exp + a[i][k] * b[k][j];
                end
                check_elem($sformatf("C[%0d][%0d]", i, j),
                           u_mem.read_word(c_base + axi_addr_t'(4 * (i * N + j))), c_exp);
            end
        end
        check_elem("word below C", u_mem.read_word(c_base - 4), u_mem.fill_word(c_base - 4));
        check_elem("word above C", u_mem.read_word(c_base + 64), u_mem.fill_word(c_base + 64));
        check_len("AR count", axi_len_t'(ar_cnt - ar_start), 8'd2);
        check_len("AW count", axi_len_t'(aw_cnt - aw_start), 8'd1);
    endtask

    initial begin
        void'($urandom(32'hff1c));
        rst_n      = 1'b0;
        start_i    = 1'b0;
        mat_a_addr = '0;
        mat_b_addr = '0;
        mat_c_addr = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // idle outputs before the first start
        repeat (4) begin
            @(negedge clk);
            check_flag("done_o after reset", done_o, 1'b1);
            check_flag("arvalid after reset", arvalid, 1'b0);
            check_flag("awvalid after reset", awvalid, 1'b0);
            check_flag("wvalid after reset", wvalid, 1'b0);
        end

        for (int n = 0; n < NUM_JOBS; n++) begin
            run_job(n >= NUM_JOBS - 3);
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/axi_pkg.sv
logic/gemm_pkg.sv
logic/tile_buffer.sv
logic/systolic_mm.sv
logic/dma_engine.sv
logic/gemm_accel.sv
tests/axi_mem_model.sv
tests/tb_gemm_accel.sv

/* Makefile */
# Verilator build and run for the gemm accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_gemm_accel
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf $(BUILD_DIR)
